/* design/norm_round_pkg.sv */
/*
  Shared widths, encodings and stage structs for the divide/sqrt normalizer.
  The datapath is sized for FP32; FP16 values sit left-aligned in it.
  Rounding-mode codes outside the four named ones act as truncate.
*/

package norm_round_pkg;

  //////////////////////////////
  // Format widths
  //////////////////////////////
  localparam int c_mant_fp32 = 23;  // Stored fraction bits
  localparam int c_exp_fp32  = 8;
  localparam int c_mant_fp16 = 10;
  localparam int c_exp_fp16  = 5;

  localparam int c_mant_w = c_mant_fp32 + 5;  // Hidden bit, fraction, 4 extra bits
  localparam int c_exp_w  = c_exp_fp32 + 2;   // Signed, one guard bit above the format

  // Canonical quiet NaN, top fraction bit only
  localparam logic [c_mant_fp32-1:0] c_mant_nan = {1'b1, {(c_mant_fp32-1){1'b0}}};
  localparam logic [c_exp_w-1:0]     c_exp_one  = 1;

  //////////////////////////////
  // Encodings
  //////////////////////////////
  typedef enum logic {
    fmt_fp32 = 1'b0,
    fmt_fp16 = 1'b1
  } fmt_e;

  typedef enum logic [2:0] {
    rnd_nearest   = 3'h0,  // Nearest, ties to even
    rnd_trunc     = 3'h1,
    rnd_plus_inf  = 3'h2,
    rnd_minus_inf = 3'h3
  } rnd_mode_e;

  typedef enum logic {
    op_div  = 1'b0,
    op_sqrt = 1'b1
  } op_e;

  //////////////////////////////
  // Stage structs
  //////////////////////////////
  typedef struct packed {
    logic nan_a;
    logic nan_b;
    logic inf_a;
    logic inf_b;
    logic zero_a;
    logic zero_b;
  } operand_class_t;

  typedef struct packed {
    logic                      sign;
    logic signed [c_exp_w-1:0] exp;   // Unbiased overflow possible in both directions
    logic [c_mant_w-1:0]       mant;  // 1.x or 0.1x plus rounding bits
  } raw_result_t;

  typedef struct packed {
    logic nv;  // Always zero here
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed {
    logic    hit;           // Operand classes decide the result
    logic    sign;
    logic    exp_all_ones;  // Else exponent is zero
    logic    mant_nan;      // Else fraction is zero
    fflags_t flags;
  } special_t;

  typedef struct packed {
    logic                  sign;
    logic [c_exp_fp32-1:0] exp;
    logic [c_mant_fp32:0]  mant;   // Hidden bit included
    logic [c_mant_w-1:0]   extra;  // Bits below mant, MSB first
    fflags_t               flags;
  } norm_t;

endpackage

/* design/special_case_resolver.sv */
/*
  Operand-class priority chain for the divide/sqrt result.
  Purely combinational. A NaN result always gets sign 0 and the
  canonical fraction; nv is never raised here.
*/

`timescale 1ns/10ps

module special_case_resolver
  import norm_round_pkg::*;
(
  input  operand_class_t cls,
  input  op_e            op,
  input  logic           sign,   // Sign of the raw quotient or root
  output special_t       special
);

  logic is_div;
  logic is_sqrt;
  logic nan_res;

  assign is_div  = (op == op_div);
  assign is_sqrt = (op == op_sqrt);

  //////////////////////////////
  // Priority chain
  //////////////////////////////
  always_comb
  begin
    special              = '0;
    special.hit          = 1'b1;  // Cleared in the final else
    special.sign         = sign;
    special.exp_all_ones = 1'b1;
    nan_res              = 1'b0;

    if (cls.nan_a)                            // NaN in a
    begin
      nan_res = 1'b1;
    end
    else if (cls.nan_b)                       // NaN in b
    begin
      nan_res = 1'b1;
    end
    else if (cls.inf_a)
    begin
      if (is_div && cls.inf_b)                // Inf/Inf
        nan_res = 1'b1;
      else
        special.flags.of = 1'b1;              // Signed Inf
    end
    else if (is_div && cls.inf_b)             // x/Inf gives zero
    begin
      special.exp_all_ones = 1'b0;
      special.flags.of     = 1'b1;
    end
    else if (cls.zero_a)
    begin
      if (is_div && cls.zero_b)               // 0/0
      begin
        nan_res          = 1'b1;
        special.flags.dz = 1'b1;
      end
      else
        special.exp_all_ones = 1'b0;          // Signed zero
    end
    else if (is_div && cls.zero_b)            // x/0 gives Inf
    begin
      special.flags.dz = 1'b1;
    end
    else if (is_sqrt && sign)                 // Root of a negative
    begin
      nan_res = 1'b1;
    end
    else
    begin
      special = '0;                           // Numeric path decides
    end

    // Canonical NaN overrides sign and fraction
    if (nan_res)
    begin
      special.sign     = 1'b0;
      special.mant_nan = 1'b1;
    end
  end

endmodule

/* design/exponent_normalizer.sv */
/*
  Numeric normalization of the raw quotient or root, per format.
  Negative exponents shift right into a denormal; the bits shifted out
  land in the extra field for sticky. A special hit overrides all of it.
*/

`timescale 1ns/10ps

module exponent_normalizer
  import norm_round_pkg::*;
(
  input  raw_result_t raw,
  input  fmt_e        fmt,
  input  special_t    special,
  output norm_t       norm
);

  logic                      is_fp16;
  logic                      exp_top_bit;   // Bit at the format width
  logic                      exp_all_set;   // All format exponent bits set
  logic signed [c_exp_w-1:0] exp_max_rs;    // Exponent after a full-mantissa right shift
  logic [c_exp_w-1:0]        num_rs;        // Right shifts to reach a denormal
  logic [c_exp_w-1:0]        exp_sub_one;
  logic [c_mant_fp32:0]      mant_rs;
  logic [c_mant_w-1:0]       mant_sticky;
  logic                      mant_msb;
  norm_t                     num;           // Numeric path result

  assign is_fp16  = (fmt == fmt_fp16);
  assign mant_msb = raw.mant[c_mant_w-1];

  //////////////////////////////
  // Format dependent checks
  //////////////////////////////
  always_comb
  begin
    if (is_fp16)
    begin
      exp_top_bit = raw.exp[c_exp_fp16];
      exp_all_set = &raw.exp[c_exp_fp16-1:0];
      exp_max_rs  = raw.exp + c_exp_w'(c_mant_fp16 + 1);
    end
    else
    begin
      exp_top_bit = raw.exp[c_exp_fp32];
      exp_all_set = &raw.exp[c_exp_fp32-1:0];
      exp_max_rs  = raw.exp + c_exp_w'(c_mant_fp32 + 1);
    end
  end

  // Shift count is 1 - exp, only meaningful for negative exponents
  assign num_rs      = c_exp_one - raw.exp;
  assign exp_sub_one = raw.exp - c_exp_one;

  assign {mant_rs, mant_sticky} = {raw.mant, {(c_mant_fp32+1){1'b0}}} >> num_rs;

  //////////////////////////////
  // Numeric path
  //////////////////////////////
  always_comb
  begin
    num       = '0;
    num.sign  = raw.sign;

    if (raw.exp == '0)
    begin
      if (raw.mant != '0)                       // Denormal, shift right once
      begin
        num.flags.uf = 1'b1;
        num.mant     = {1'b0, raw.mant[c_mant_w-1:5]};
        num.extra    = {raw.mant[4:0], {(c_mant_w-5){1'b0}}};
      end
    end
    else if ((raw.exp == c_exp_one) && !mant_msb) // Denormal, no shift
    begin
      num.flags.uf = 1'b1;
      num.mant     = raw.mant[c_mant_w-1:4];
      num.extra    = {raw.mant[3:0], {(c_mant_w-4){1'b0}}};
    end
    else if (raw.exp[c_exp_w-1])                // Negative exponent
    begin
      if (exp_max_rs[c_exp_w-1])
        num.flags.of = 1'b1;                    // Nothing left, signed zero
      else
      begin
        num.flags.uf = 1'b1;
        num.mant     = mant_rs;
        num.extra    = mant_sticky;
      end
    end
    else if (exp_top_bit)                       // Past the format range
    begin
      num.flags.of = 1'b1;
      num.exp      = '1;
    end
    else if (exp_all_set)
    begin
      if (!mant_msb)                            // 0.1x pulls it back in range
      begin
        num.exp   = exp_sub_one[c_exp_fp32-1:0];
        num.mant  = raw.mant[c_mant_w-2:3];
        num.extra = {raw.mant[2:0], {(c_mant_w-3){1'b0}}};
      end
      else
      begin
        num.flags.of = 1'b1;                    // Inf
        num.exp      = '1;
      end
    end
    else if (mant_msb)                          // Normal 1.x
    begin
      num.exp   = raw.exp[c_exp_fp32-1:0];
      num.mant  = raw.mant[c_mant_w-1:4];
      num.extra = {raw.mant[3:0], {(c_mant_w-4){1'b0}}};
    end
    else                                        // Normal 0.1x
    begin
      num.exp   = exp_sub_one[c_exp_fp32-1:0];
      num.mant  = raw.mant[c_mant_w-2:3];
      num.extra = {raw.mant[2:0], {(c_mant_w-3){1'b0}}};
    end
  end

  //////////////////////////////
  // Special override
  //////////////////////////////
  always_comb
  begin
    if (special.hit)
    begin
      norm       = '0;                          // Zero extra, never rounds
      norm.sign  = special.sign;
      norm.exp   = special.exp_all_ones ? '1 : '0;
      norm.mant  = special.mant_nan ? {1'b0, c_mant_nan} : '0;
      norm.flags = special.flags;
    end
    else
      norm = num;
  end

endmodule

/* design/mantissa_rounder.sv */
/*
  Rounds the normalized mantissa at the last fraction bit of the format.
  FP16 fractions come out left-aligned in the 23-bit frac port.
  nx follows the round-up decision; a carry out bumps the exponent.
*/

`timescale 1ns/10ps

module mantissa_rounder
  import norm_round_pkg::*;
(
  input  norm_t                 norm,
  input  fmt_e                  fmt,
  input  rnd_mode_e             rnd_mode,
  output logic [c_exp_fp32-1:0] exp,
  output logic [c_mant_fp32-1:0] frac,
  output fflags_t               flags
);

  logic [c_mant_fp32:0]   mant_upper;    // Kept bits, hidden bit on top
  logic [1:0]             mant_lower;    // Guard and round
  logic                   sticky;
  logic                   last_bit;      // LSB of the kept fraction
  logic                   inexact;
  logic                   round_up;
  logic [c_mant_fp32:0]   round_vec;
  logic [c_mant_fp32+1:0] mant_rounded;
  logic                   renorm;

  //////////////////////////////
  // Guard, round, sticky
  //////////////////////////////
  always_comb
  begin
    if (fmt == fmt_fp16)
    begin
      mant_upper = {norm.mant[c_mant_fp32:c_mant_fp32-c_mant_fp16],
                    {(c_mant_fp32-c_mant_fp16){1'b0}}};
      mant_lower = norm.mant[c_mant_fp32-c_mant_fp16-1 -: 2];
      sticky     = |{norm.mant[c_mant_fp32-c_mant_fp16-3:0], norm.extra};
      last_bit   = norm.mant[c_mant_fp32-c_mant_fp16];
    end
    else
    begin
      mant_upper = norm.mant;
      mant_lower = norm.extra[c_mant_w-1 -: 2];  // First two bits below mant
      sticky     = |norm.extra[c_mant_w-3:0];
      last_bit   = norm.mant[0];
    end
  end

  assign inexact = (|mant_lower) | sticky;

  //////////////////////////////
  // Round-up decision
  //////////////////////////////
  always_comb
  begin
    case (rnd_mode)
      rnd_nearest:
        round_up = mant_lower[1] && (mant_lower[0] || sticky || last_bit);
      rnd_trunc:
        round_up = 1'b0;
      rnd_plus_inf:
        round_up = inexact && !norm.sign;
      rnd_minus_inf:
        round_up = inexact && norm.sign;
      default:
        round_up = 1'b0;                   // Unknown codes truncate
    endcase
  end

  // One ULP at the format's last fraction bit
  always_comb
  begin
    round_vec = '0;
    if (fmt == fmt_fp16)
      round_vec[c_mant_fp32-c_mant_fp16] = round_up;
    else
      round_vec[0] = round_up;
  end

  //////////////////////////////
  // Add and renormalize
  //////////////////////////////
  assign mant_rounded = {1'b0, mant_upper} + {1'b0, round_vec};
  assign renorm       = mant_rounded[c_mant_fp32+1];  // Carry out of 1.111

  assign frac = renorm ? mant_rounded[c_mant_fp32:1] : mant_rounded[c_mant_fp32-1:0];
  assign exp  = norm.exp + c_exp_fp32'(renorm);

  always_comb
  begin
    flags    = norm.flags;
    flags.nx = round_up;
  end

endmodule

/* design/norm_round_unit.sv */
/*
  Top of the divide/sqrt normalize and round stage.
  One output register stage, latency one cycle, no back-pressure.
  Outputs only mean something while out_valid is high.
  FP16 results are NaN-boxed with ones in the upper half.
*/

`timescale 1ns/10ps

module norm_round_unit
  import norm_round_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           in_valid,
  input  raw_result_t    in_raw,
  input  operand_class_t in_class,
  input  op_e            op,
  input  fmt_e           fmt,
  input  rnd_mode_e      rnd_mode,
  output logic           out_valid,
  output logic [31:0]    result,
  output fflags_t        fflags
);

  special_t               special;
  norm_t                  norm;
  logic [c_exp_fp32-1:0]  rnd_exp;
  logic [c_mant_fp32-1:0] rnd_frac;
  fflags_t                rnd_flags;
  logic [31:0]            result_d;   // Packed and boxed, before the register

  //////////////////////////////
  // Combinational stages
  //////////////////////////////
  special_case_resolver u_special (
    .cls     (in_class),
    .op      (op),
    .sign    (in_raw.sign),
    .special (special)
  );

  exponent_normalizer u_normalizer (
    .raw     (in_raw),
    .fmt     (fmt),
    .special (special),
    .norm    (norm)
  );

  mantissa_rounder u_rounder (
    .norm     (norm),
    .fmt      (fmt),
    .rnd_mode (rnd_mode),
    .exp      (rnd_exp),
    .frac     (rnd_frac),
    .flags    (rnd_flags)
  );

  // Field packing per format
  always_comb
  begin
    if (fmt == fmt_fp16)
      result_d = {16'hffff, norm.sign, rnd_exp[c_exp_fp16-1:0],
                  rnd_frac[c_mant_fp32-1 -: c_mant_fp16]};  // Fraction is left-aligned
    else
      result_d = {norm.sign, rnd_exp, rnd_frac};
  end

  //////////////////////////////
  // Output register
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
      result    <= '0;
      fflags    <= '0;
    end
    else
    begin
      out_valid <= in_valid;
      if (in_valid)             // Hold last answer between items
      begin
        result <= result_d;
        fflags <= rnd_flags;
      end
    end
  end

endmodule

/* testbench/norm_round_checker.sv */
/*
  Reference model and scoreboard for the normalize and round stage.
  Predicts each answer from the inputs seen with in_valid and expects it
  exactly one cycle later. Checks start once reset is released.
*/

`timescale 1ns/10ps

module norm_round_checker
  import norm_round_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           in_valid,
  input  raw_result_t    in_raw,
  input  operand_class_t in_class,
  input  op_e            op,
  input  fmt_e           fmt,
  input  rnd_mode_e      rnd_mode,
  input  logic           out_valid,
  input  logic [31:0]    result,
  input  fflags_t        fflags,
  output int             checks,
  output int             value_errors,
  output int             protocol_errors
);

  logic        exp_valid;   // Prediction for the current cycle
  logic [31:0] exp_result;
  fflags_t     exp_flags;
  logic        exp_boxed;
  string       exp_name;

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic void predict(
    input  raw_result_t    raw,
    input  operand_class_t cls,
    input  op_e            oper,
    input  fmt_e           f,
    input  rnd_mode_e      mode,
    output logic [31:0]    res,
    output fflags_t        flg,
    output string          name
  );
    logic                      fp16;
    logic                      div;
    logic                      nan;
    logic                      inf;
    logic                      hit;
    logic signed [c_exp_w-1:0] e;
    logic [c_mant_w-1:0]       m;
    logic [51:0]               v;     // Hidden bit at the top, then all lower bits
    logic [51:0]               kept;
    logic [51:0]               rounded;
    logic [51:0]               frac;
    logic [7:0]                ex;
    logic                      guard;
    logic                      rnd;
    logic                      sticky;
    logic                      up;
    logic                      carry;
    int                        w;
    int                        nf;
    int                        emask;
    string                     prefix;
    string                     kind;

    fp16   = (f == fmt_fp16);
    div    = (oper == op_div);
    w      = fp16 ? c_exp_fp16 : c_exp_fp32;
    nf     = fp16 ? c_mant_fp16 : c_mant_fp32;
    emask  = (1 << w) - 1;
    prefix = fp16 ? "fp16_" : "fp32_";
    e      = raw.exp;
    m      = raw.mant;
    flg    = '0;
    nan    = 1'b0;
    inf    = 1'b0;
    hit    = 1'b1;

    // Operand classes first, highest priority on top
    if (cls.nan_a || cls.nan_b)
      nan = 1'b1;
    else if (cls.inf_a)
    begin
      if (div && cls.inf_b)
        nan = 1'b1;
      else
      begin
        inf    = 1'b1;
        flg.of = 1'b1;
      end
    end
    else if (div && cls.inf_b)
      flg.of = 1'b1;                        // Zero result
    else if (cls.zero_a)
    begin
      if (div && cls.zero_b)
      begin
        nan    = 1'b1;
        flg.dz = 1'b1;
      end
    end
    else if (div && cls.zero_b)
    begin
      inf    = 1'b1;
      flg.dz = 1'b1;
    end
    else if (!div && raw.sign)
      nan = 1'b1;                           // Root of a negative
    else
      hit = 1'b0;

    if (hit)
    begin
      kind = nan ? "special_nan" : (inf ? "special_inf" : "special_zero");
      if (nan)
        res = fp16 ? 32'hffff7e00 : 32'h7fc00000;  // Sign 0, quiet bit only
      else if (inf)
        res = fp16 ? {16'hffff, raw.sign, 5'h1f, 10'h0} : {raw.sign, 8'hff, 23'h0};
      else
        res = fp16 ? {16'hffff, raw.sign, 15'h0} : {raw.sign, 31'h0};
      name = {prefix, kind};
      return;
    end

    // Numeric path, exponent rules
    ex   = 8'h0;
    v    = '0;
    kind = "normal";
    if (e == 0)
    begin
      kind = "zero_exp";
      if (m != '0)
      begin
        flg.uf = 1'b1;
        v      = {1'b0, m, 23'b0};          // One step right
      end
    end
    else if ((e == 1) && !m[27])
    begin
      kind   = "denormal";
      flg.uf = 1'b1;
      v      = {m, 24'b0};
    end
    else if (e < 0)
    begin
      kind = "denormal";
      if (int'(e) + nf + 1 < 0)
      begin
        kind   = "underflow_zero";
        flg.of = 1'b1;
      end
      else
      begin
        flg.uf = 1'b1;
        v      = {m, 24'b0} >> (1 - int'(e));
      end
    end
    else if (e[w])
    begin
      kind   = "overflow";
      flg.of = 1'b1;
      ex     = 8'hff;
    end
    else if ((int'(e) & emask) == emask)
    begin
      kind = "top_exp";
      if (!m[27])
      begin
        ex = e[7:0] - 8'd1;
        v  = {m, 24'b0} << 1;
      end
      else
      begin
        flg.of = 1'b1;
        ex     = 8'hff;
      end
    end
    else if (m[27])
    begin
      ex = e[7:0];
      v  = {m, 24'b0};
    end
    else
    begin
      ex = e[7:0] - 8'd1;
      v  = {m, 24'b0} << 1;
    end

    // Rounding at the last fraction bit of the format
    kept   = v >> (51 - nf);
    guard  = v[50 - nf];
    rnd    = v[49 - nf];
    sticky = |(v & ((52'd1 << (49 - nf)) - 52'd1));
    case (mode)
      rnd_nearest:   up = guard && (rnd || sticky || kept[0]);
      rnd_plus_inf:  up = (guard || rnd || sticky) && !raw.sign;
      rnd_minus_inf: up = (guard || rnd || sticky) && raw.sign;
      default:       up = 1'b0;             // Truncate, also unknown codes
    endcase
    rounded = kept + 52'(up);
    carry   = rounded[nf + 1];
    frac    = (carry ? (rounded >> 1) : rounded) & ((52'd1 << nf) - 52'd1);
    ex      = ex + {7'b0, carry};
    flg.nx  = up;

    if (fp16)
      res = {16'hffff, raw.sign, ex[4:0], frac[9:0]};
    else
      res = {raw.sign, ex, frac[22:0]};
    name = {prefix, kind};
  endfunction

  //////////////////////////////
  // Compare, then predict
  //////////////////////////////
  initial
  begin
    checks          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    exp_valid       = 1'b0;
  end

  always @(posedge clk)
  begin : compare_and_predict
    logic [31:0] res_next;
    fflags_t     flg_next;
    string       name_next;

    if (!reset)
    begin
      if (out_valid !== exp_valid)
      begin
        protocol_errors++;
        if (exp_valid)
          $display("Output missing at %0t: out_valid stayed low after an accepted input",
                   $time);
        else
          $display("Unexpected output at %0t: out_valid is %b with no input a cycle before",
                   $time, out_valid);
      end
      else if (exp_valid)
      begin
        checks++;
        if (result !== exp_result)
        begin
          value_errors++;
          $display("CHECK FAILED %s: result expected %h actual %h",
                   exp_name, exp_result, result);
        end
        if (fflags !== exp_flags)
        begin
          value_errors++;
          $display("CHECK FAILED %s: fflags expected %b actual %b",
                   exp_name, exp_flags, fflags);
        end
        if (exp_boxed && (result[31:16] !== 16'hffff))  // FP16 boxing
        begin
          value_errors++;
          $display("CHECK FAILED %s_boxing: upper half expected ffff actual %h",
                   exp_name, result[31:16]);
        end
      end
    end

    if (reset)
      exp_valid = 1'b0;
    else
    begin
      exp_valid = in_valid;
      if (in_valid)
      begin
        predict(in_raw, in_class, op, fmt, rnd_mode, res_next, flg_next, name_next);
        exp_result = res_next;
        exp_flags  = flg_next;
        exp_boxed  = (fmt == fmt_fp16);
        exp_name   = name_next;
      end
    end
  end

endmodule

/* testbench/tb_norm_round_unit.sv */
/*
  Testbench for the normalize and round stage.
  Directed class and exponent corners, then xorshift vectors from seed 24.
  Inputs change on the rising edge; the checker does all comparing.
*/

`timescale 1ns/10ps

module tb_norm_round_unit
  import norm_round_pkg::*;
;

  localparam int c_clk_period  = 20;
  localparam int c_num_class   = 128;   // 64 class patterns with both ops
  localparam int c_num_edge    = 16;
  localparam int c_num_random  = 2000;
  localparam int c_num_vectors = c_num_class + c_num_edge + c_num_random;
  localparam int c_watchdog_ns = (c_num_vectors + 50) * c_clk_period;

  logic           clk;
  logic           reset;
  logic           in_valid;
  raw_result_t    in_raw;
  operand_class_t in_class;
  op_e            op;
  fmt_e           fmt;
  rnd_mode_e      rnd_mode;
  logic           out_valid;
  logic [31:0]    result;
  fflags_t        fflags;
  int             checks;
  int             value_errors;
  int             protocol_errors;
  int             sent;
  logic [31:0]    rng_state;

  norm_round_unit UUT (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_raw(in_raw),
    .in_class(in_class), .op(op), .fmt(fmt), .rnd_mode(rnd_mode),
    .out_valid(out_valid), .result(result), .fflags(fflags)
  );

  norm_round_checker u_checker (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_raw(in_raw),
    .in_class(in_class), .op(op), .fmt(fmt), .rnd_mode(rnd_mode),
    .out_valid(out_valid), .result(result), .fflags(fflags),
    .checks(checks), .value_errors(value_errors), .protocol_errors(protocol_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever #(c_clk_period / 2) clk = ~clk;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Called just after a rising edge and sampled at the next one
  task automatic drive_vector(input raw_result_t raw, input operand_class_t cls,
                              input op_e o, input fmt_e f, input rnd_mode_e md);
    in_valid <= 1'b1;
    in_raw   <= raw;
    in_class <= cls;
    op       <= o;
    fmt      <= f;
    rnd_mode <= md;
    @(posedge clk);
    sent++;
  endtask

  task automatic idle_cycles(input int n);
    in_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic drive_numeric(input logic s, input int e, input logic [c_mant_w-1:0] m,
                               input fmt_e f, input rnd_mode_e md);
    raw_result_t raw;
    raw.sign = s;
    raw.exp  = c_exp_w'(e);
    raw.mant = m;
    drive_vector(raw, '0, op_div, f, md);
  endtask

  task automatic drive_random_vector();
    logic [31:0]    r;
    logic [31:0]    c;
    logic [31:0]    e;
    logic [31:0]    m;
    raw_result_t    raw;
    operand_class_t cls;
    fmt_e           f;
    logic [2:0]     code;
    int             lo;
    int             span;
    r = next_random();
    c = next_random();
    e = next_random();
    m = next_random();
    f = fmt_e'(r[0]);
    // Each flag set one time in eight so specials are common
    cls = operand_class_t'({c[2:0] == 3'd0, c[5:3] == 3'd0, c[8:6] == 3'd0,
                            c[11:9] == 3'd0, c[14:12] == 3'd0, c[17:15] == 3'd0});
    code = (r[7:5] == 3'd0) ? {1'b1, r[3:2]} : {1'b0, r[3:2]};  // Rare unknown codes
    case (e[1:0])
      2'd0:
      begin
        lo   = (f == fmt_fp16) ? -16 : -30;   // Denormal and underflow range
        span = (f == fmt_fp16) ? 18 : 32;
      end
      2'd1:
      begin
        lo   = (f == fmt_fp16) ? 28 : 250;    // Around the top exponent
        span = (f == fmt_fp16) ? 8 : 12;
      end
      default:
      begin
        lo   = 1;
        span = (f == fmt_fp16) ? 30 : 254;
      end
    endcase
    raw.sign = r[8];
    raw.exp  = c_exp_w'(lo + int'(e[23:8]) % span);
    raw.mant = m[c_mant_w-1:0];
    if (m[28])
      raw.mant[27] = 1'b1;                  // 1.x
    else
      raw.mant[27:26] = 2'b01;              // 0.1x
    if (m[31:29] == 3'b111)
      raw.mant[25:4] = '1;                  // Likely rounding carry
    drive_vector(raw, cls, op_e'(r[1]), f, rnd_mode_e'(code));
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    raw_result_t base;
    sent      = 0;
    rng_state = 32'd24;
    reset    <= 1'b1;
    in_valid <= 1'b0;
    in_raw   <= '0;
    in_class <= '0;
    op       <= op_div;
    fmt      <= fmt_fp32;
    rnd_mode <= rnd_nearest;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(2);                         // out_valid must stay low

    // Every class pattern with both ops back to back
    for (int i = 0; i < c_num_class; i++)
    begin
      base.sign = i[0];
      base.exp  = c_exp_w'(100);
      base.mant = 28'h9abcdef;
      drive_vector(base, operand_class_t'(i[6:1]), op_e'(i[0]),
                   fmt_e'(i[1]), rnd_nearest);
    end
    idle_cycles(3);

    drive_numeric(1'b0, 100, 28'hfffffff, fmt_fp32, rnd_nearest);    // Carry renormalize
    drive_numeric(1'b0, 15, 28'hfffffff, fmt_fp16, rnd_nearest);
    drive_numeric(1'b0, 0, 28'h8000011, fmt_fp32, rnd_nearest);      // Zero exponent
    drive_numeric(1'b1, 0, 28'h0000000, fmt_fp32, rnd_nearest);
    drive_numeric(1'b0, 1, 28'h6000000, fmt_fp32, rnd_trunc);        // Exponent one with 0.1x
    drive_numeric(1'b0, -5, 28'hc000003, fmt_fp32, rnd_plus_inf);
    drive_numeric(1'b1, -30, 28'h8000000, fmt_fp32, rnd_nearest);    // Nothing left
    drive_numeric(1'b0, -12, 28'h8000000, fmt_fp16, rnd_nearest);
    drive_numeric(1'b0, -8, 28'hf000000, fmt_fp16, rnd_plus_inf);
    drive_numeric(1'b0, 255, 28'h4000001, fmt_fp32, rnd_nearest);    // All-ones exponent
    drive_numeric(1'b1, 255, 28'h8000000, fmt_fp32, rnd_nearest);
    drive_numeric(1'b0, 256, 28'h8000000, fmt_fp32, rnd_nearest);    // Past the range
    drive_numeric(1'b0, 31, 28'h5000000, fmt_fp16, rnd_minus_inf);
    drive_numeric(1'b1, 32, 28'h8000000, fmt_fp16, rnd_nearest);
    drive_numeric(1'b0, 10, 28'h8000018, fmt_fp32, rnd_nearest);     // Tie to even
    drive_numeric(1'b1, 10, 28'h8000001, fmt_fp32, rnd_minus_inf);
    idle_cycles(3);

    for (int i = 0; i < c_num_random; i++)
      drive_random_vector();
    idle_cycles(2);                         // Latency is one cycle
    @(negedge clk);

    $display("Checked %0d of %0d results, %0d value errors, %0d protocol errors",
             checks, sent, value_errors, protocol_errors);
    if ((value_errors == 0) && (protocol_errors == 0) && (checks == sent))
      $display("Result: PASSED");
    else
    begin
      if (checks != sent)
        $display("Some driven vectors never produced a checked result");
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(c_watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", c_watchdog_ns);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* norm_round_unit.f */
design/norm_round_pkg.sv
design/special_case_resolver.sv
design/exponent_normalizer.sv
design/mantissa_rounder.sv
design/norm_round_unit.sv
testbench/norm_round_checker.sv
testbench/tb_norm_round_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator; exit status follows the result.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_norm_round_unit -f norm_round_unit.f -o tb_norm_round_unit \
  && ./obj_dir/tb_norm_round_unit > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^Result: PASSED$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
